//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = ex_stage_tb
FILELIST  = verilog.f
PASS_TEXT = RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

//--- hdl/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
	input  logic          clock,
	input  logic          reset,
	input  logic          branch_start,
	input  ex_pkg::xlen_t rs1,
	input  ex_pkg::xlen_t rs2,
	input  ex_pkg::xlen_t opa,
	input  ex_pkg::xlen_t opb,
	input  logic [2:0]    funct3,
	input  logic          is_cond,
	input  logic          is_uncond,
	output logic          take_branch,
	output ex_pkg::xlen_t branch_target
);
	import ex_pkg::*;

	logic  cond;
	xlen_t target;

	// condition from funct3 of the branch
	always_comb begin
		cond = 1'b0;
		case (funct3)
			3'b000: cond = (rs1 == rs2);                  // beq
			3'b001: cond = (rs1 != rs2);                  // bne
			3'b100: cond = ($signed(rs1) < $signed(rs2));  // blt
			3'b101: cond = ($signed(rs1) >= $signed(rs2)); // bge
			3'b110: cond = (rs1 < rs2);                   // bltu
			3'b111: cond = (rs1 >= rs2);                  // bgeu
			default: cond = 1'b0;
		endcase
	end

	assign target = opa + opb;

	// outcome lives for one cycle only
	always_ff @(posedge clock) begin
		if (reset) begin
			take_branch   <= 1'b0;
			branch_target <= '0;
		end else begin
			take_branch   <= branch_start && (is_uncond || (is_cond && cond));
			branch_target <= branch_start ? target : '0;
		end
	end

endmodule

//--- hdl/completion_queue.sv
`timescale 1ns/100ps

module completion_queue (
	input  logic          clock,
	input  logic          reset,
	input  logic          mult_done,
	input  ex_pkg::tag_t  mult_tag,
	input  ex_pkg::xlen_t mult_product,
	input  logic          alu_start,
	input  ex_pkg::tag_t  alu_tag,
	input  ex_pkg::xlen_t alu_result,
	input  logic          branch_start,
	input  ex_pkg::tag_t  branch_tag,
	input  ex_pkg::xlen_t branch_link,
	output logic          complete_valid,
	output ex_pkg::tag_t  complete_tag,
	output ex_pkg::xlen_t complete_result,
	output logic          reg_wr_en
);
	import ex_pkg::*;

	tag_t       tag_mem    [QUEUE_DEPTH];
	xlen_t      result_mem [QUEUE_DEPTH];
	qptr_t      head;
	qptr_t      tail;
	qcount_t    count;
	qcount_t    count_next;
	logic       single_valid;
	tag_t       single_tag;
	xlen_t      single_result;
	qptr_t      single_ptr;
	logic [1:0] num_writes;
	logic       pop;

	// alu and branch never start together
	assign single_valid  = alu_start | branch_start;
	assign single_tag    = branch_start ? branch_tag : alu_tag;
	assign single_result = branch_start ? branch_link : alu_result;

	// multiply takes the tail slot first
	assign single_ptr = mult_done ? qptr_t'(tail + 1'b1) : tail;
	assign num_writes = {1'b0, mult_done} + {1'b0, single_valid};
	assign pop        = complete_valid; // no downstream stall
	assign count_next = count + qcount_t'(num_writes) - qcount_t'(pop);

	////////////////////////////////////////
	// storage
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (mult_done) begin
			tag_mem[tail]    <= mult_tag;
			result_mem[tail] <= mult_product;
		end
		if (single_valid) begin
			tag_mem[single_ptr]    <= single_tag;
			result_mem[single_ptr] <= single_result;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			head  <= qptr_t'(head + pop);
			tail  <= qptr_t'(tail + num_writes);
			count <= count_next;
		end
	end

	assign complete_valid  = (count != '0);
	assign complete_tag    = tag_mem[head];
	assign complete_result = result_mem[head];
	assign reg_wr_en       = complete_valid && (complete_tag != ZERO_TAG);

	// results in flight must fit, nothing upstream can stall
	queue_no_overflow: assert property (@(posedge clock) disable iff (reset)
		count_next <= QUEUE_DEPTH);

endmodule

//--- hdl/ex_pkg.sv
package ex_pkg;

	////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////
	localparam int XLEN           = 32;
	localparam int TAG_BITS       = 6;
	localparam int MULT_STAGES    = 4;
	localparam int MULT_SLICE     = 2 * XLEN / MULT_STAGES; // multiplier bits per stage
	localparam int QUEUE_DEPTH    = 8;
	localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);

	typedef logic [XLEN-1:0]           xlen_t;
	typedef logic [2*XLEN-1:0]         dword_t;  // full product
	typedef logic [TAG_BITS-1:0]       tag_t;
	typedef logic [31:0]               inst_t;
	typedef logic [QUEUE_PTR_BITS-1:0] qptr_t;
	typedef logic [QUEUE_PTR_BITS:0]   qcount_t; // 0 up to QUEUE_DEPTH

	localparam tag_t ZERO_TAG = '0; // no destination, no register write

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////
	typedef enum logic [1:0] {
		UNIT_ALU    = 2'd0,
		UNIT_MULT   = 2'd1,
		UNIT_BRANCH = 2'd2
	} exec_unit_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_SRA  = 4'd9
	} alu_func_t;

	typedef enum logic [1:0] {
		MULT_MUL    = 2'd0, // low half
		MULT_MULH   = 2'd1, // signed x signed
		MULT_MULHSU = 2'd2, // signed x unsigned
		MULT_MULHU  = 2'd3  // unsigned x unsigned
	} mult_func_t;

	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'd0,
		OPA_IS_NPC  = 2'd1,
		OPA_IS_PC   = 2'd2,
		OPA_IS_ZERO = 2'd3
	} opa_sel_t;

	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'd0,
		OPB_IS_I_IMM = 3'd1,
		OPB_IS_S_IMM = 3'd2,
		OPB_IS_B_IMM = 3'd3,
		OPB_IS_U_IMM = 3'd4,
		OPB_IS_J_IMM = 3'd5
	} opb_sel_t;

endpackage

//--- hdl/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
	input  logic               clock,
	input  logic               reset,
	input  logic               issue_valid,
	input  ex_pkg::exec_unit_t issue_unit,
	input  ex_pkg::xlen_t      pc,
	input  ex_pkg::inst_t      inst,
	input  ex_pkg::xlen_t      rs1_value,
	input  ex_pkg::xlen_t      rs2_value,
	input  ex_pkg::opa_sel_t   opa_select,
	input  ex_pkg::opb_sel_t   opb_select,
	input  ex_pkg::alu_func_t  alu_func,
	input  ex_pkg::mult_func_t mult_func,
	input  logic               cond_branch,
	input  logic               uncond_branch,
	input  ex_pkg::tag_t       dest_tag,
	output logic               complete_valid,
	output ex_pkg::tag_t       complete_tag,
	output ex_pkg::xlen_t      complete_result,
	output logic               reg_wr_en,
	output logic               take_branch,
	output ex_pkg::xlen_t      branch_target
);
	import ex_pkg::*;

	logic       alu_start;
	logic       mult_start;
	logic       branch_start;
	xlen_t      opa;
	xlen_t      opb;
	xlen_t      rs1_out;
	xlen_t      rs2_out;
	xlen_t      npc;
	alu_func_t  func_alu;
	mult_func_t func_mult;
	logic [2:0] branch_funct3;
	logic       is_cond;
	logic       is_uncond;
	tag_t       issue_tag;   // tag of the registered instruction
	xlen_t      alu_result;
	logic       mult_done;
	tag_t       mult_tag;
	xlen_t      mult_product;

	operand_select u_operand_select (
		.clock         (clock),
		.reset         (reset),
		.issue_valid   (issue_valid),
		.issue_unit    (issue_unit),
		.pc            (pc),
		.inst          (inst),
		.rs1_value     (rs1_value),
		.rs2_value     (rs2_value),
		.opa_select    (opa_select),
		.opb_select    (opb_select),
		.alu_func      (alu_func),
		.mult_func     (mult_func),
		.cond_branch   (cond_branch),
		.uncond_branch (uncond_branch),
		.dest_tag      (dest_tag),
		.alu_start     (alu_start),
		.mult_start    (mult_start),
		.branch_start  (branch_start),
		.opa           (opa),
		.opb           (opb),
		.rs1_out       (rs1_out),
		.rs2_out       (rs2_out),
		.npc           (npc),
		.func_alu      (func_alu),
		.func_mult     (func_mult),
		.branch_funct3 (branch_funct3),
		.is_cond       (is_cond),
		.is_uncond     (is_uncond),
		.tag_out       (issue_tag)
	);

	int_alu u_int_alu (
		.opa    (opa),
		.opb    (opb),
		.func   (func_alu),
		.result (alu_result)
	);

	branch_unit u_branch_unit (
		.clock         (clock),
		.reset         (reset),
		.branch_start  (branch_start),
		.rs1           (rs1_out),
		.rs2           (rs2_out),
		.opa           (opa),
		.opb           (opb),
		.funct3        (branch_funct3),
		.is_cond       (is_cond),
		.is_uncond     (is_uncond),
		.take_branch   (take_branch),
		.branch_target (branch_target)
	);

	pipelined_mult u_pipelined_mult (
		.clock   (clock),
		.reset   (reset),
		.start   (mult_start),
		.mcand   (rs1_out),
		.mplier  (rs2_out),
		.func    (func_mult),
		.tag_in  (issue_tag),
		.done    (mult_done),
		.tag_out (mult_tag),
		.product (mult_product)
	);

	// a branch completes with its link value
	completion_queue u_completion_queue (
		.clock           (clock),
		.reset           (reset),
		.mult_done       (mult_done),
		.mult_tag        (mult_tag),
		.mult_product    (mult_product),
		.alu_start       (alu_start),
		.alu_tag         (issue_tag),
		.alu_result      (alu_result),
		.branch_start    (branch_start),
		.branch_tag      (issue_tag),
		.branch_link     (npc),
		.complete_valid  (complete_valid),
		.complete_tag    (complete_tag),
		.complete_result (complete_result),
		.reg_wr_en       (reg_wr_en)
	);

endmodule

//--- hdl/int_alu.sv
`timescale 1ns/100ps

module int_alu (
	input  ex_pkg::xlen_t     opa,
	input  ex_pkg::xlen_t     opb,
	input  ex_pkg::alu_func_t func,
	output ex_pkg::xlen_t     result
);
	import ex_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = opb[4:0]; // rv32 shifts use five bits
	assign lt_signed   = $signed(opa) < $signed(opb);
	assign lt_unsigned = opa < opb;

	always_comb begin
		result = '0; // encodings 10 to 15 unused
		case (func)
			ALU_ADD:  result = opa + opb;
			ALU_SUB:  result = opa - opb;
			ALU_AND:  result = opa & opb;
			ALU_OR:   result = opa | opb;
			ALU_XOR:  result = opa ^ opb;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_SLL:  result = opa << shamt;
			ALU_SRL:  result = opa >> shamt;
			ALU_SRA:  result = $signed(opa) >>> shamt; // sign bit fills from the left
		endcase
	end

endmodule

//--- hdl/mult_stage.sv
`timescale 1ns/100ps

module mult_stage (
	input  logic           clock,
	input  logic           reset,
	input  logic           start,
	input  ex_pkg::dword_t mcand_in,
	input  ex_pkg::dword_t mplier_in,
	input  ex_pkg::dword_t product_in,
	input  ex_pkg::tag_t   tag_in,
	output logic           done,
	output ex_pkg::dword_t mcand_out,
	output ex_pkg::dword_t mplier_out,
	output ex_pkg::dword_t product_out,
	output ex_pkg::tag_t   tag_out
);
	import ex_pkg::*;

	dword_t partial;

	// one slice of the multiplier against the shifted multiplicand
	assign partial = dword_t'(mplier_in[MULT_SLICE-1:0]) * mcand_in;

	always_ff @(posedge clock) begin
		product_out <= product_in + partial;
		mcand_out   <= mcand_in << MULT_SLICE;
		mplier_out  <= mplier_in >> MULT_SLICE; // next slice moves down
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done    <= 1'b0;
			tag_out <= '0;
		end else begin
			done    <= start;
			tag_out <= tag_in;
		end
	end

endmodule

//--- hdl/operand_select.sv
`timescale 1ns/100ps

module operand_select (
	input  logic               clock,
	input  logic               reset,
	input  logic               issue_valid,
	input  ex_pkg::exec_unit_t issue_unit,
	input  ex_pkg::xlen_t      pc,
	input  ex_pkg::inst_t      inst,
	input  ex_pkg::xlen_t      rs1_value,
	input  ex_pkg::xlen_t      rs2_value,
	input  ex_pkg::opa_sel_t   opa_select,
	input  ex_pkg::opb_sel_t   opb_select,
	input  ex_pkg::alu_func_t  alu_func,
	input  ex_pkg::mult_func_t mult_func,
	input  logic               cond_branch,
	input  logic               uncond_branch,
	input  ex_pkg::tag_t       dest_tag,
	output logic               alu_start,
	output logic               mult_start,
	output logic               branch_start,
	output ex_pkg::xlen_t      opa,
	output ex_pkg::xlen_t      opb,
	output ex_pkg::xlen_t      rs1_out,
	output ex_pkg::xlen_t      rs2_out,
	output ex_pkg::xlen_t      npc,
	output ex_pkg::alu_func_t  func_alu,
	output ex_pkg::mult_func_t func_mult,
	output logic [2:0]         branch_funct3,
	output logic               is_cond,
	output logic               is_uncond,
	output ex_pkg::tag_t       tag_out
);
	import ex_pkg::*;

	logic       valid_q;
	exec_unit_t unit_q;
	xlen_t      pc_q;
	inst_t      inst_q;
	opa_sel_t   opa_sel_q;
	opb_sel_t   opb_sel_q;
	xlen_t      imm_i;
	xlen_t      imm_s;
	xlen_t      imm_b;
	xlen_t      imm_u;
	xlen_t      imm_j;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue_valid;
		end
	end

	// payload only loads on an issue
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			unit_q    <= issue_unit;
			pc_q      <= pc;
			inst_q    <= inst;
			rs1_out   <= rs1_value;
			rs2_out   <= rs2_value;
			opa_sel_q <= opa_select;
			opb_sel_q <= opb_select;
			func_alu  <= alu_func;
			func_mult <= mult_func;
			is_cond   <= cond_branch;
			is_uncond <= uncond_branch;
			tag_out   <= dest_tag;
		end
	end

	assign alu_start    = valid_q && (unit_q == UNIT_ALU);
	assign mult_start   = valid_q && (unit_q == UNIT_MULT);
	assign branch_start = valid_q && (unit_q == UNIT_BRANCH);

	////////////////////////////////////////
	// immediate decode
	////////////////////////////////////////
	assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
	assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
	assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
	assign imm_u = {inst_q[31:12], 12'b0};
	assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

	assign npc           = pc_q + 32'd4;
	assign branch_funct3 = inst_q[14:12];

	always_comb begin
		case (opa_sel_q)
			OPA_IS_RS1:  opa = rs1_out;
			OPA_IS_NPC:  opa = npc;
			OPA_IS_PC:   opa = pc_q;
			OPA_IS_ZERO: opa = '0;
		endcase
	end

	always_comb begin
		opb = '0; // encodings 6 and 7 unused
		case (opb_sel_q)
			OPB_IS_RS2:   opb = rs2_out;
			OPB_IS_I_IMM: opb = imm_i;
			OPB_IS_S_IMM: opb = imm_s;
			OPB_IS_B_IMM: opb = imm_b;
			OPB_IS_U_IMM: opb = imm_u;
			OPB_IS_J_IMM: opb = imm_j;
		endcase
	end

	// the issuer must never route to the unused unit code
	issue_unit_legal: assert property (@(posedge clock) disable iff (reset)
		issue_valid |-> issue_unit inside {UNIT_ALU, UNIT_MULT, UNIT_BRANCH});

endmodule

//--- hdl/pipelined_mult.sv
`timescale 1ns/100ps

module pipelined_mult (
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	input  ex_pkg::xlen_t      mcand,
	input  ex_pkg::xlen_t      mplier,
	input  ex_pkg::mult_func_t func,
	input  ex_pkg::tag_t       tag_in,
	output logic               done,
	output ex_pkg::tag_t       tag_out,
	output ex_pkg::xlen_t      product
);
	import ex_pkg::*;

	logic                 mcand_signed;
	logic                 mplier_signed;
	logic [MULT_STAGES:0] done_chain;
	dword_t               mcand_chain   [MULT_STAGES+1];
	dword_t               mplier_chain  [MULT_STAGES+1];
	dword_t               product_chain [MULT_STAGES+1];
	tag_t                 tag_chain     [MULT_STAGES+1];
	mult_func_t           func_pipe     [MULT_STAGES];
	dword_t               full_product;

	assign mcand_signed  = (func == MULT_MULH) || (func == MULT_MULHSU);
	assign mplier_signed = (func == MULT_MULH);

	// widen to 64 bits so the low half of the product is exact
	assign mcand_chain[0]   = {{XLEN{mcand_signed & mcand[XLEN-1]}}, mcand};
	assign mplier_chain[0]  = {{XLEN{mplier_signed & mplier[XLEN-1]}}, mplier};
	assign product_chain[0] = '0;
	assign done_chain[0]    = start;
	assign tag_chain[0]     = tag_in;

	for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
		mult_stage stage (
			.clock       (clock),
			.reset       (reset),
			.start       (done_chain[i]),
			.mcand_in    (mcand_chain[i]),
			.mplier_in   (mplier_chain[i]),
			.product_in  (product_chain[i]),
			.tag_in      (tag_chain[i]),
			.done        (done_chain[i+1]),
			.mcand_out   (mcand_chain[i+1]),
			.mplier_out  (mplier_chain[i+1]),
			.product_out (product_chain[i+1]),
			.tag_out     (tag_chain[i+1])
		);
	end

	// function code rides along with the chain
	always_ff @(posedge clock) begin
		func_pipe[0] <= func;
		for (int s = 1; s < MULT_STAGES; s++) begin
			func_pipe[s] <= func_pipe[s-1];
		end
	end

	assign full_product = product_chain[MULT_STAGES];

	////////////////////////////////////////
	// output register with half select
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (func_pipe[MULT_STAGES-1] == MULT_MUL) begin
			product <= full_product[XLEN-1:0];
		end else begin
			product <= full_product[2*XLEN-1:XLEN];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done    <= 1'b0;
			tag_out <= '0;
		end else begin
			done    <= done_chain[MULT_STAGES];
			tag_out <= tag_chain[MULT_STAGES];
		end
	end

	// every done belongs to a start a fixed depth back
	done_follows_start: assert property (@(posedge clock) disable iff (reset)
		done |-> $past(start, MULT_STAGES + 1));

endmodule

//--- tb/ex_stage_stim.txt
# gap jitter unit pc inst rs1 rs2 opa_sel opb_sel alu_func mult_func cond uncond tag expected
# unit 0 alu 1 mult 2 branch; pc inst rs1 rs2 expected in hex, the rest decimal
3 0 0 00001000 00000000 00000005 00000007 0 0 0 0 0 0 1 0000000c
2 0 0 00001004 00000000 00000010 00000020 0 0 1 0 0 0 0 fffffff0
0 1 0 00001008 00000000 f0f0f0f0 0ff00ff0 0 0 2 0 0 0 2 00f000f0
0 1 0 0000100c 00000000 f0000000 0000000f 0 0 3 0 0 0 3 f000000f
0 1 0 00001010 00000000 aaaaaaaa ffff0000 0 0 4 0 0 0 4 5555aaaa
0 1 0 00001014 00000000 ffffffff 00000001 0 0 5 0 0 0 5 00000001
0 1 0 00001018 00000000 ffffffff 00000001 0 0 6 0 0 0 6 00000000
0 1 0 0000101c 00000000 00000001 00000024 0 0 7 0 0 0 7 00000010
0 1 0 00001020 00000000 80000000 00000004 0 0 8 0 0 0 8 08000000
0 1 0 00001024 00000000 80000000 00000004 0 0 9 0 0 0 9 f8000000
0 1 0 00000100 12300000 00000000 00000000 1 1 0 0 0 0 10 00000227
0 1 0 00000200 fe000080 00000000 00000000 2 2 0 0 0 0 11 000001e1
0 1 0 00000204 abcde000 00000000 00000000 3 4 0 0 0 0 12 abcde000
0 1 0 00000208 00000f00 00000010 00000000 0 3 0 0 0 0 13 0000002e
0 1 0 00000300 00100000 00000000 00000000 2 5 0 0 0 0 14 00000b00
1 1 1 00000400 00000000 00000007 00000006 0 0 0 0 0 0 15 0000002a
0 0 1 00000404 00000000 fffffffe 00000003 0 0 0 1 0 0 16 ffffffff
0 0 1 00000408 00000000 ffffffff ffffffff 0 0 0 2 0 0 17 ffffffff
0 0 1 0000040c 00000000 ffffffff ffffffff 0 0 0 3 0 0 18 fffffffe
0 0 1 00000410 00000000 80000000 80000000 0 0 0 1 0 0 19 40000000
6 0 1 00000414 00000000 00001234 00000010 0 0 0 0 0 0 20 00012340
4 0 0 00000418 00000000 00000001 00000002 0 0 0 0 0 0 21 00000003
2 1 2 00000400 00000f00 00000005 00000005 2 3 0 0 1 0 22 00000404
0 0 2 00000500 00001f00 00000005 00000005 2 3 0 0 1 0 23 00000504
0 1 2 00000600 00004f00 ffffffff 00000001 2 3 0 0 1 0 24 00000604
0 0 2 00000700 00005f00 ffffffff 00000001 2 3 0 0 1 0 25 00000704
0 1 2 00000800 00006f00 ffffffff 00000001 2 3 0 0 1 0 26 00000804
0 0 2 00000900 00007f00 ffffffff 00000001 2 3 0 0 1 0 27 00000904
0 0 2 00000a00 00100000 00000000 00000000 2 5 0 0 0 1 28 00000a04

//--- tb/ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb;
	import ex_pkg::*;

	localparam int MAX_TESTS = 64;
	localparam int MAX_IN_FLIGHT = 6;

	logic       clock;
	logic       reset;
	logic       issue_valid;
	exec_unit_t issue_unit;
	xlen_t      pc;
	inst_t      inst;
	xlen_t      rs1_value;
	xlen_t      rs2_value;
	opa_sel_t   opa_select;
	opb_sel_t   opb_select;
	alu_func_t  alu_func;
	mult_func_t mult_func;
	logic       cond_branch;
	logic       uncond_branch;
	tag_t       dest_tag;
	logic       complete_valid;
	tag_t       complete_tag;
	xlen_t      complete_result;
	logic       reg_wr_en;
	logic       take_branch;
	xlen_t      branch_target;

	// stimulus columns with one entry per test
	int    n_tests;
	int    gap [MAX_TESTS];
	int    unit_col [MAX_TESTS];
	int    opa_col [MAX_TESTS];
	int    opb_col [MAX_TESTS];
	int    alu_col [MAX_TESTS];
	int    mul_col [MAX_TESTS];
	int    cond_col [MAX_TESTS];
	int    unc_col [MAX_TESTS];
	int    tag_col [MAX_TESTS];
	xlen_t pc_col [MAX_TESTS];
	inst_t inst_col [MAX_TESTS];
	xlen_t rs1_col [MAX_TESTS];
	xlen_t rs2_col [MAX_TESTS];
	xlen_t file_exp [MAX_TESTS];

	// bookkeeping by tag
	xlen_t exp_result [MAX_TESTS];
	int    write_cyc [MAX_TESTS];
	int    test_of_tag [MAX_TESTS];
	bit    pending [MAX_TESTS];

	int    br_due [$];
	bit    br_take [$];
	xlen_t br_target [$];

	int cyc = 0;
	int limit = 100000;
	int issued = 0;
	int completed = 0;
	int checks = 0;
	int errors = 0;
	int last_done = -1;

	ex_stage DUT (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// cycle counter and run limit
	always @(posedge clock) begin
		cyc <= cyc + 1;
		if (cyc > limit) begin
			$display("timeout: run passed %0d cycles with %0d of %0d tests done",
				limit, completed, n_tests);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	function automatic xlen_t operand_a(int sel, xlen_t pc_v, xlen_t rs1_v);
		case (sel)
			0: return rs1_v;
			1: return pc_v + 32'd4;
			2: return pc_v;
			default: return 32'd0;
		endcase
	endfunction

	function automatic xlen_t operand_b(int sel, inst_t in, xlen_t rs2_v);
		case (sel)
			1: return 32'($signed(in[31:20]));
			2: return 32'($signed({in[31:25], in[11:7]}));
			3: return 32'($signed({in[31], in[7], in[30:25], in[11:8], 1'b0}));
			4: return {in[31:12], 12'h000};
			5: return 32'($signed({in[31], in[19:12], in[20], in[30:21], 1'b0}));
			default: return rs2_v;
		endcase
	endfunction

	function automatic xlen_t model_value(int t);
		xlen_t       a;
		xlen_t       b;
		logic [63:0] wa;
		logic [63:0] wb;
		logic [63:0] prod;
		a = operand_a(opa_col[t], pc_col[t], rs1_col[t]);
		b = operand_b(opb_col[t], inst_col[t], rs2_col[t]);
		if (unit_col[t] == 2)
			return pc_col[t] + 32'd4; // link value
		if (unit_col[t] == 1) begin
			wa = (mul_col[t] == 1 || mul_col[t] == 2) ? 64'($signed(rs1_col[t]))
				: {32'd0, rs1_col[t]};
			wb = (mul_col[t] == 1) ? 64'($signed(rs2_col[t])) : {32'd0, rs2_col[t]};
			prod = wa * wb;
			return (mul_col[t] == 0) ? prod[31:0] : prod[63:32];
		end
		case (alu_col[t])
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			6: return (a < b) ? 32'd1 : 32'd0;
			7: return a << b[4:0];
			8: return a >> b[4:0];
			default: return xlen_t'($signed(a) >>> b[4:0]);
		endcase
	endfunction

	function automatic bit model_taken(int t);
		xlen_t r1;
		xlen_t r2;
		r1 = rs1_col[t];
		r2 = rs2_col[t];
		if (unc_col[t] != 0)
			return 1'b1;
		if (cond_col[t] == 0)
			return 1'b0;
		case (inst_col[t][14:12])
			3'd0: return r1 == r2;
			3'd1: return r1 != r2;
			3'd4: return $signed(r1) < $signed(r2);
			3'd5: return $signed(r1) >= $signed(r2);
			3'd6: return r1 < r2;
			3'd7: return r1 >= r2;
			default: return 1'b0;
		endcase
	endfunction

	// entries written on the same edge leave multiply first
	function automatic int queue_rank(int tg);
		return write_cyc[tg] * 2 + ((unit_col[test_of_tag[tg]] == 1) ? 0 : 1);
	endfunction

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_result(string name, xlen_t act, xlen_t exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
		end
	endtask

	task automatic check_tag(string name, tag_t act, tag_t exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, act, exp);
		end
	endtask

	task automatic check_branch(bit act_take, xlen_t act_tgt, bit exp_take, xlen_t exp_tgt);
		checks++;
		if (act_take !== exp_take || act_tgt !== exp_tgt) begin
			errors++;
			$display("mismatch at %0t: take_branch/branch_target got %b/%h expected %b/%h",
				$time, act_take, act_tgt, exp_take, exp_tgt);
		end
	endtask

	task automatic check_bit(string name, logic act, logic exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %b expected %b", $time, name, act, exp);
		end
	endtask

	////////////////////////////////////////
	// per cycle monitor at the falling edge
	////////////////////////////////////////
	task automatic watch_outputs();
		int   oldest;
		int   t;
		int   err_before;
		int   due;
		tag_t tg;
		tag_t exp_tag;
		if (br_due.size() > 0 && br_due[0] == cyc) begin
			check_branch(take_branch, branch_target, br_take[0], br_target[0]);
			void'(br_due.pop_front());
			void'(br_take.pop_front());
			void'(br_target.pop_front());
		end else begin
			check_branch(take_branch, branch_target, 1'b0, 32'd0);
		end
		if (complete_valid !== 1'b1) begin
			check_bit("reg_wr_en", reg_wr_en, 1'b0);
			return;
		end
		tg = complete_tag;
		if (!pending[tg]) begin
			errors++;
			$display("completion at %0t carries tag %0d, which is not in flight", $time, tg);
			return;
		end
		err_before = errors;
		oldest = -1;
		for (int k = 0; k < MAX_TESTS; k++) begin
			if (pending[k] && (oldest < 0 || queue_rank(k) < queue_rank(oldest)))
				oldest = k;
		end
		exp_tag = tag_t'(oldest);
		check_tag("complete_tag", tg, exp_tag);
		check_result("complete_result", complete_result, exp_result[tg]);
		check_bit("reg_wr_en", reg_wr_en, exp_tag != ZERO_TAG);
		// one completion per cycle, never before the entry is written
		due = (write_cyc[tg] > last_done + 1) ? write_cyc[tg] : last_done + 1;
		if (cyc != due) begin
			errors++;
			$display("tag %0d completed at cycle %0d instead of cycle %0d",
				tg, cyc, due);
		end
		last_done = cyc;
		t = test_of_tag[tg];
		$display("test %0d tag %0d unit %0d: %s", t, tg, unit_col[t],
			(errors == err_before) ? "ok" : "failed");
		pending[tg] = 0;
		completed++;
	endtask

	task automatic tick();
		@(negedge clock);
		watch_outputs();
	endtask

	////////////////////////////////////////
	// stimulus file
	////////////////////////////////////////
	task automatic read_stimulus();
		int    fd;
		int    jit;
		int    total;
		string line;
		fd = $fopen("tb/ex_stage_stim.txt", "r");
		n_tests = 0;
		if (fd == 0) begin
			errors++;
			$display("cannot open tb/ex_stage_stim.txt so no tests can run");
		end else begin
			total = 0;
			while (!$feof(fd) && n_tests < MAX_TESTS) begin
				if ($fgets(line, fd) == 0 || line.len() < 4 || line.substr(0, 0) == "#")
					continue;
				if ($sscanf(line, "%d %d %d %h %h %h %h %d %d %d %d %d %d %d %h",
						gap[n_tests], jit, unit_col[n_tests], pc_col[n_tests],
						inst_col[n_tests], rs1_col[n_tests], rs2_col[n_tests],
						opa_col[n_tests], opb_col[n_tests], alu_col[n_tests],
						mul_col[n_tests], cond_col[n_tests], unc_col[n_tests],
						tag_col[n_tests], file_exp[n_tests]) != 15)
					continue;
				if (jit != 0)
					gap[n_tests] += $urandom % 3; // random extra idle cycles
				total += gap[n_tests];
				n_tests++;
			end
			$fclose(fd);
			limit = total + n_tests * 10 + 50;
		end
	endtask

	initial begin
		int    seed_ret;
		int    t;
		xlen_t model;
		seed_ret = $urandom(32'hae19ca51);
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_unit = UNIT_ALU;
		pc = '0;
		inst = '0;
		rs1_value = '0;
		rs2_value = '0;
		opa_select = OPA_IS_RS1;
		opb_select = OPB_IS_RS2;
		alu_func = ALU_ADD;
		mult_func = MULT_MUL;
		cond_branch = 1'b0;
		uncond_branch = 1'b0;
		dest_tag = '0;
		read_stimulus();
		// model against the file before anything runs
		for (t = 0; t < n_tests; t++) begin
			model = model_value(t);
			checks++;
			if (model !== file_exp[t]) begin
				errors++;
				$display("stimulus line %0d lists %h but the model gives %h",
					t, file_exp[t], model);
			end
		end
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		for (t = 0; t < n_tests; t++) begin
			issue_valid = 1'b0;
			repeat (gap[t]) tick();
			while (issued - completed >= MAX_IN_FLIGHT)
				tick();
			issue_unit = exec_unit_t'(unit_col[t][1:0]);
			pc = pc_col[t];
			inst = inst_col[t];
			rs1_value = rs1_col[t];
			rs2_value = rs2_col[t];
			opa_select = opa_sel_t'(opa_col[t][1:0]);
			opb_select = opb_sel_t'(opb_col[t][2:0]);
			alu_func = alu_func_t'(alu_col[t][3:0]);
			mult_func = mult_func_t'(mul_col[t][1:0]);
			cond_branch = cond_col[t][0];
			uncond_branch = unc_col[t][0];
			dest_tag = tag_t'(tag_col[t]);
			issue_valid = 1'b1;
			exp_result[tag_col[t]] = file_exp[t];
			write_cyc[tag_col[t]] = cyc + ((unit_col[t] == 1) ? 7 : 2);
			test_of_tag[tag_col[t]] = t;
			pending[tag_col[t]] = 1;
			issued++;
			if (unit_col[t] == 2) begin
				br_due.push_back(cyc + 2);
				br_take.push_back(model_taken(t));
				br_target.push_back(operand_a(opa_col[t], pc_col[t], rs1_col[t])
					+ operand_b(opb_col[t], inst_col[t], rs2_col[t]));
			end
			tick();
		end
		issue_valid = 1'b0;
		while (completed < n_tests)
			tick();
		repeat (3) tick();

		$display("%0d tests, %0d completed, %0d checks, %0d errors",
			n_tests, completed, checks, errors);
		if (errors == 0 && completed == n_tests) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- verilog.f
hdl/ex_pkg.sv
hdl/operand_select.sv
hdl/int_alu.sv
hdl/branch_unit.sv
hdl/mult_stage.sv
hdl/pipelined_mult.sv
hdl/completion_queue.sv
hdl/ex_stage.sv
tb/ex_stage_tb.sv
